/* design/buffer_pkg.sv */
/* sizes of the sample banks, command opcodes, capture FSM states
   and the command word with its two decode views */
package buffer_pkg;

  // bank geometry
  localparam int bank_depth  = 16;
  localparam int bank_aw     = 4;
  // one bank's depth count, 0 to 16
  localparam int depth_w     = 5;
  // write count over both banks, 0 to 32
  localparam int cnt_w       = depth_w + 1;
  localparam int total_depth = 2 * bank_depth;
  localparam int sample_w    = 16;

  // command opcodes
  localparam int op_w = 3;
  localparam int flag_w = 5;
  localparam logic [op_w-1:0] op_arm           = 3'd0;
  localparam logic [op_w-1:0] op_bank_mode     = 3'd1;
  localparam logic [op_w-1:0] op_capture_reset = 3'd2;
  localparam logic [op_w-1:0] op_readout_reset = 3'd3;
  localparam logic [op_w-1:0] op_readout_start = 3'd4;

  // command word, opcode always in the top three bits
  // ctl view: flag bit at the opcode's index confirms the command
  // cfg view: banking mode bit right below the opcode
  typedef union packed {
    struct packed {
      logic [op_w-1:0]   op;
      logic [flag_w-1:0] flags;
    } ctl;
    struct packed {
      logic [op_w-1:0] op;
      logic            mode;
      logic [3:0]      rsvd;
    } cfg;
  } cmd_word_u;

  // capture FSM states, also seen by the readout gate
  typedef enum logic [1:0] {
    cap_idle,
    cap_armed,
    cap_saving,
    cap_hold
  } cap_state_e;

endpackage

/* design/cmd_decode.sv */
/* command decoder: strobed command word to registered control pulses,
   plus the banking mode register */
`timescale 1ns/1ps
module cmd_decode import buffer_pkg::*; (
  input  logic      ps_clk,
  input  logic      rst_i,
  input  logic      cmd_valid_i,
  input  cmd_word_u cmd_i,
  input  logic      cap_idle_i,
  output logic      arm_o,
  output logic      cap_rst_o,
  output logic      rd_rst_o,
  output logic      rd_start_o,
  output logic      bank_mode_o
);

  logic arm_q;
  logic cap_rst_q;
  logic rd_rst_q;
  logic rd_start_q;
  logic mode_q;

  always_ff @(posedge ps_clk) begin
    if (rst_i) begin
      arm_q      <= 1'b0;
      cap_rst_q  <= 1'b0;
      rd_rst_q   <= 1'b0;
      rd_start_q <= 1'b0;
      // one bank per channel out of reset
      mode_q     <= 1'b1;
    end else begin
      // pulses last a single cycle
      arm_q      <= 1'b0;
      cap_rst_q  <= 1'b0;
      rd_rst_q   <= 1'b0;
      rd_start_q <= 1'b0;
      if (cmd_valid_i) begin
        case (cmd_i.ctl.op)
          // flag commands need their confirm bit
          op_arm:           arm_q      <= cmd_i.ctl.flags[op_arm];
          op_capture_reset: cap_rst_q  <= cmd_i.ctl.flags[op_capture_reset];
          op_readout_reset: rd_rst_q   <= cmd_i.ctl.flags[op_readout_reset];
          op_readout_start: rd_start_q <= cmd_i.ctl.flags[op_readout_start];
          op_bank_mode: begin
            // mode only changes between captures
            if (cap_idle_i) begin
              mode_q <= cmd_i.cfg.mode;
            end
          end
          // unknown opcodes are dropped
          default: mode_q <= mode_q;
        endcase
      end
    end
  end

  assign arm_o       = arm_q;
  assign cap_rst_o   = cap_rst_q;
  assign rd_rst_o    = rd_rst_q;
  assign rd_start_o  = rd_start_q;
  assign bank_mode_o = mode_q;

endmodule

/* design/capture_fsm.sv */
/* capture FSM: arm, start and stop control, bank write addressing,
   full detection and the one-shot depth report */
`timescale 1ns/1ps
module capture_fsm import buffer_pkg::*; (
  input  logic               ps_clk,
  input  logic               rst_i,
  input  logic               arm_i,
  input  logic               cap_rst_i,
  input  logic               bank_mode_i,
  input  logic               hw_start_i,
  input  logic               hw_stop_i,
  input  logic               sample_valid_i,
  output cap_state_e         state_o,
  output logic               we0_o,
  output logic               we1_o,
  output logic [bank_aw-1:0] waddr_o,
  output logic               wsel_o,
  output logic               full_o,
  output logic               depth_valid_o,
  output logic [depth_w-1:0] depth0_o,
  output logic [depth_w-1:0] depth1_o
);

  cap_state_e         state_q;
  cap_state_e         state_d;
  logic [cnt_w-1:0]   count_q;
  logic [cnt_w-1:0]   count_nxt;
  logic [cnt_w-1:0]   limit;
  logic               wr;
  logic               fill;
  logic               first_hold;
  logic               reported_q;
  logic               full_q;
  logic               depth_valid_q;
  logic [depth_w-1:0] depth0_q;
  logic [depth_w-1:0] depth1_q;
  logic [depth_w-1:0] split0;
  logic [depth_w-1:0] split1;

  // a sample pair is stored on every valid cycle while saving
  assign wr        = (state_q == cap_saving) && sample_valid_i;
  assign count_nxt = count_q + cnt_w'(1);
  // mode 0 chains both banks for channel 0
  assign limit     = bank_mode_i ? cnt_w'(bank_depth) : cnt_w'(total_depth);
  assign fill      = wr && (count_nxt == limit);
  // first cycle spent in hold since the last capture reset
  assign first_hold = (state_q == cap_hold) && !reported_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cap_idle:   if (arm_i) state_d = cap_armed;
      cap_armed:  if (hw_start_i) state_d = cap_saving;
      // the filling write still lands before hold
      cap_saving: if (hw_stop_i || fill) state_d = cap_hold;
      // hold only leaves through capture reset
      default:    state_d = state_q;
    endcase
  end

  // per-bank depths from the single write count
  always_comb begin
    if (bank_mode_i) begin
      split0 = count_q[depth_w-1:0];
      split1 = count_q[depth_w-1:0];
    end else if (count_q >= cnt_w'(bank_depth)) begin
      split0 = depth_w'(bank_depth);
      split1 = depth_w'(count_q - cnt_w'(bank_depth));
    end else begin
      split0 = count_q[depth_w-1:0];
      split1 = '0;
    end
  end

  always_ff @(posedge ps_clk) begin
    if (rst_i || cap_rst_i) begin
      state_q       <= cap_idle;
      count_q       <= '0;
      full_q        <= 1'b0;
      reported_q    <= 1'b0;
      depth_valid_q <= 1'b0;
      depth0_q      <= '0;
      depth1_q      <= '0;
    end else begin
      state_q <= state_d;
      if (wr) begin
        count_q <= count_nxt;
      end
      // full sticks until capture reset
      if (fill) begin
        full_q <= 1'b1;
      end
      // depth report fires once, a cycle after entering hold
      depth_valid_q <= first_hold;
      if (first_hold) begin
        reported_q <= 1'b1;
        depth0_q   <= split0;
        depth1_q   <= split1;
      end
    end
  end

  // mode 1 writes both banks at one address, mode 0 picks the bank by count msb
  assign we0_o   = wr && (bank_mode_i || !count_q[bank_aw]);
  assign we1_o   = wr && (bank_mode_i || count_q[bank_aw]);
  assign waddr_o = count_q[bank_aw-1:0];
  // steer channel 0 into bank 1 in mode 0
  assign wsel_o  = !bank_mode_i;

  assign state_o       = state_q;
  assign full_o        = full_q;
  assign depth_valid_o = depth_valid_q;
  assign depth0_o      = depth0_q;
  assign depth1_o      = depth1_q;

endmodule

/* design/sample_banks.sv */
/* two sample memories with write-side channel steering
   and a registered, bank-muxed read port */
`timescale 1ns/1ps
module sample_banks import buffer_pkg::*; (
  input  logic                ps_clk,
  input  logic                we0_i,
  input  logic                we1_i,
  input  logic [bank_aw-1:0]  waddr_i,
  input  logic                wsel_i,
  input  logic [sample_w-1:0] ch0_i,
  input  logic [sample_w-1:0] ch1_i,
  input  logic [bank_aw-1:0]  raddr_i,
  input  logic                rsel_i,
  output logic [sample_w-1:0] rdata_o
);

  // bank index first, then sample address
  logic [sample_w-1:0] mem [2][bank_depth];
  logic [sample_w-1:0] wdata [2];
  logic [1:0]          we;
  logic [sample_w-1:0] rdata_q;

  // bank 0 always holds channel 0
  assign wdata[0] = ch0_i;
  // bank 1 holds channel 1, or the upper half of channel 0 in mode 0
  assign wdata[1] = wsel_i ? ch0_i : ch1_i;
  assign we       = {we1_i, we0_i};

  // same write port for both banks
  for (genvar b = 0; b < 2; b++) begin : g_bank
    always_ff @(posedge ps_clk) begin
      if (we[b]) begin
        mem[b][waddr_i] <= wdata[b];
      end
    end
  end

  // one cycle read latency
  always_ff @(posedge ps_clk) begin
    rdata_q <= mem[rsel_i][raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

/* design/readout_engine.sv */
/* readout sequencer: walks bank 0 then bank 1 up to their depths
   and tracks the registered read with a valid and last stage */
`timescale 1ns/1ps
module readout_engine import buffer_pkg::*; (
  input  logic                ps_clk,
  input  logic                rst_i,
  input  logic                start_i,
  input  logic                rst_rd_i,
  input  logic                cap_rst_i,
  input  cap_state_e          state_i,
  input  logic [depth_w-1:0]  depth0_i,
  input  logic [depth_w-1:0]  depth1_i,
  input  logic [sample_w-1:0] rdata_i,
  output logic [bank_aw-1:0]  raddr_o,
  output logic                rsel_o,
  output logic                rd_valid_o,
  output logic [sample_w-1:0] rd_data_o,
  output logic                rd_last_o,
  output logic                rd_busy_o
);

  logic               issue_q;
  logic               issue_last_q;
  logic               valid_q;
  logic               last_q;
  logic               rsel_q;
  logic [bank_aw-1:0] raddr_q;
  logic [cnt_w-1:0]   total;
  logic [depth_w-1:0] end0;
  logic [depth_w-1:0] end1;
  logic               go;
  logic               adv;
  logic               next_sel;
  logic [bank_aw-1:0] next_addr;
  logic               next_last;

  // last address of each bank
  assign end0  = depth0_i - depth_w'(1);
  assign end1  = depth1_i - depth_w'(1);
  assign total = cnt_w'(depth0_i) + cnt_w'(depth1_i);

  // only start from hold with something stored, and not mid-stream
  assign go  = start_i && (state_i == cap_hold) && (total != '0) && !rd_busy_o;
  // load the first address on start, step until the last one is issued
  assign adv = go || (issue_q && !issue_last_q);

  always_comb begin
    if (!issue_q) begin
      // empty bank 0 goes straight to bank 1
      next_sel  = (depth0_i == '0);
      next_addr = '0;
    end else if (!rsel_q && (depth_w'(raddr_q) == end0)) begin
      next_sel  = 1'b1;
      next_addr = '0;
    end else begin
      next_sel  = rsel_q;
      next_addr = raddr_q + bank_aw'(1);
    end
    // bank 0 ends the stream only when bank 1 is empty
    if (next_sel) begin
      next_last = (depth_w'(next_addr) == end1);
    end else begin
      next_last = (depth_w'(next_addr) == end0) && (depth1_i == '0);
    end
  end

  always_ff @(posedge ps_clk) begin
    if (rst_i || rst_rd_i || cap_rst_i) begin
      issue_q      <= 1'b0;
      issue_last_q <= 1'b0;
      valid_q      <= 1'b0;
      last_q       <= 1'b0;
    end else begin
      // valid and last follow the read address by one cycle
      valid_q <= issue_q;
      last_q  <= issue_q && issue_last_q;
      if (adv) begin
        issue_q      <= 1'b1;
        issue_last_q <= next_last;
      end else begin
        issue_q <= 1'b0;
      end
    end
  end

  // read address registers
  always_ff @(posedge ps_clk) begin
    if (adv) begin
      rsel_q  <= next_sel;
      raddr_q <= next_addr;
    end
  end

  assign raddr_o    = raddr_q;
  assign rsel_o     = rsel_q;
  assign rd_valid_o = valid_q;
  assign rd_last_o  = last_q;
  // bank read port is already registered
  assign rd_data_o  = rdata_i;
  assign rd_busy_o  = issue_q || valid_q;

endmodule

/* design/sample_buffer_top.sv */
/* capture buffer top: command decode, capture FSM,
   sample banks and readout engine */
`timescale 1ns/1ps
module sample_buffer_top import buffer_pkg::*; (
  input  logic                ps_clk,
  input  logic                rst_i,
  input  logic                cmd_valid_i,
  input  cmd_word_u           cmd_i,
  input  logic                hw_start_i,
  input  logic                hw_stop_i,
  input  logic                sample_valid_i,
  input  logic [sample_w-1:0] ch0_i,
  input  logic [sample_w-1:0] ch1_i,
  output logic                full_o,
  output logic                depth_valid_o,
  output logic [depth_w-1:0]  depth0_o,
  output logic [depth_w-1:0]  depth1_o,
  output logic                rd_valid_o,
  output logic [sample_w-1:0] rd_data_o,
  output logic                rd_last_o,
  output logic                rd_busy_o
);

  // decode to execute
  logic arm_p;
  logic cap_rst_p;
  logic rd_rst_p;
  logic rd_start_p;
  logic bank_mode;
  // execute to banks
  cap_state_e         state;
  logic               we0;
  logic               we1;
  logic [bank_aw-1:0] waddr;
  logic               wsel;
  // result to banks
  logic [bank_aw-1:0]  raddr;
  logic                rsel;
  logic [sample_w-1:0] rdata;

  // banking mode is locked once capture leaves idle
  wire cap_idle_w = (state == cap_idle);

  cmd_decode u_decode (
    .ps_clk      (ps_clk),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cap_idle_i  (cap_idle_w),
    .arm_o       (arm_p),
    .cap_rst_o   (cap_rst_p),
    .rd_rst_o    (rd_rst_p),
    .rd_start_o  (rd_start_p),
    .bank_mode_o (bank_mode)
  );

  capture_fsm u_capture (
    .ps_clk         (ps_clk),
    .rst_i          (rst_i),
    .arm_i          (arm_p),
    .cap_rst_i      (cap_rst_p),
    .bank_mode_i    (bank_mode),
    .hw_start_i     (hw_start_i),
    .hw_stop_i      (hw_stop_i),
    .sample_valid_i (sample_valid_i),
    .state_o        (state),
    .we0_o          (we0),
    .we1_o          (we1),
    .waddr_o        (waddr),
    .wsel_o         (wsel),
    .full_o         (full_o),
    .depth_valid_o  (depth_valid_o),
    .depth0_o       (depth0_o),
    .depth1_o       (depth1_o)
  );

  sample_banks u_banks (
    .ps_clk  (ps_clk),
    .we0_i   (we0),
    .we1_i   (we1),
    .waddr_i (waddr),
    .wsel_i  (wsel),
    .ch0_i   (ch0_i),
    .ch1_i   (ch1_i),
    .raddr_i (raddr),
    .rsel_i  (rsel),
    .rdata_o (rdata)
  );

  readout_engine u_readout (
    .ps_clk     (ps_clk),
    .rst_i      (rst_i),
    .start_i    (rd_start_p),
    .rst_rd_i   (rd_rst_p),
    .cap_rst_i  (cap_rst_p),
    .state_i    (state),
    .depth0_i   (depth0_o),
    .depth1_i   (depth1_o),
    .rdata_i    (rdata),
    .raddr_o    (raddr),
    .rsel_o     (rsel),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .rd_last_o  (rd_last_o),
    .rd_busy_o  (rd_busy_o)
  );

endmodule

/* bench/buffer_tb.sv */
/* testbench for the capture buffer: clock and reset, LCG samples,
   table-driven capture, depth report and readout checks */
`timescale 1ns/1ps
module buffer_tb import buffer_pkg::*; ();

  logic                ps_clk;
  logic                rst_i;
  logic                cmd_valid_i;
  cmd_word_u           cmd_i;
  logic                hw_start_i;
  logic                hw_stop_i;
  logic                sample_valid_i;
  logic [sample_w-1:0] ch0_i;
  logic [sample_w-1:0] ch1_i;
  logic                full_o;
  logic                depth_valid_o;
  logic [depth_w-1:0]  depth0_o;
  logic [depth_w-1:0]  depth1_o;
  logic                rd_valid_o;
  logic [sample_w-1:0] rd_data_o;
  logic                rd_last_o;
  logic                rd_busy_o;

  // current row name, LCG state and the stored-sample model
  reg [8*24-1:0]       test_name;
  logic [31:0]         lcg_state;
  logic [sample_w-1:0] q0[$];
  logic [sample_w-1:0] q1[$];
  logic [sample_w-1:0] exp_q[$];
  bit                  saving_m;
  int                  limit_m;
  int                  depth_pulses = 0;

  sample_buffer_top u_dut (.*);

  initial begin
    ps_clk = 1'b0;
    forever #50 ps_clk = ~ps_clk;
  end

  // depth reports are counted on the falling edge
  always @(negedge ps_clk) begin
    if (!rst_i && depth_valid_o) begin
      depth_pulses <= depth_pulses + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_now(input string why);
    $display("%0s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string what, input logic [31:0] expv,
                           input logic [31:0] actv);
    if (expv !== actv) begin
      $display("** Error: test %0s, %0s: expected %0h, actual %0h",
               test_name, what, expv, actv);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // one strobe that returns after its pulse has acted on the FSM
  task automatic send_cmd(input logic [op_w-1:0] op, input logic mode);
    cmd_word_u c;
    c = '0;
    if (op == op_bank_mode) begin
      c.cfg.op   = op;
      c.cfg.mode = mode;
    end else begin
      // confirm flag sits at the opcode's index
      c.ctl.op        = op;
      c.ctl.flags[op] = 1'b1;
    end
    cmd_i       = c;
    cmd_valid_i = 1'b1;
    @(negedge ps_clk);
    cmd_valid_i = 1'b0;
    @(negedge ps_clk);
  endtask

  task automatic send_samples(input int n);
    logic [31:0] r;
    logic [sample_w-1:0] a;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      a = r[31:16];
      r = lcg_next();
      sample_valid_i = 1'b1;
      ch0_i = a;
      ch1_i = r[31:16];
      // model keeps pairs while saving until the active banks fill
      if (saving_m) begin
        q0.push_back(a);
        q1.push_back(r[31:16]);
        if (q0.size() == limit_m) saving_m = 1'b0;
      end
      @(negedge ps_clk);
    end
    sample_valid_i = 1'b0;
  endtask

  task automatic capture(input bit arm, input int n, input bit stop);
    q0.delete();
    q1.delete();
    saving_m = 1'b0;
    if (arm) send_cmd(op_arm, 1'b0);
    // start pulse is ignored unless armed
    hw_start_i = 1'b1;
    @(negedge ps_clk);
    hw_start_i = 1'b0;
    saving_m = arm;
    send_samples(n);
    if (stop) begin
      hw_stop_i = 1'b1;
      @(negedge ps_clk);
      hw_stop_i = 1'b0;
      saving_m = 1'b0;
    end
  endtask

  task automatic wait_report(input bit expect_one, input int base);
    int t;
    t = 0;
    while (expect_one && depth_pulses == base && t < 40) begin
      @(posedge ps_clk);
      t++;
    end
    if (expect_one && depth_pulses == base) fail_now("timeout waiting for depth_valid_o");
    // the report must not repeat in the quiet window
    repeat (12) @(posedge ps_clk);
    check_val("depth_valid_o pulses", expect_one, depth_pulses - base);
    @(negedge ps_clk);
  endtask

  task automatic wait_valid();
    int t;
    t = 0;
    while (!rd_valid_o && t < 20) begin
      @(negedge ps_clk);
      t++;
    end
    if (!rd_valid_o) fail_now("timeout waiting for rd_valid_o");
  endtask

  task automatic read_stream();
    send_cmd(op_readout_start, 1'b0);
    if (exp_q.size() == 0) begin
      // start is ignored with nothing to read
      repeat (10) begin
        check_val("rd_valid_o", 0, rd_valid_o);
        @(negedge ps_clk);
      end
    end else begin
      wait_valid();
      // no gaps and last only on the final word
      for (int i = 0; i < exp_q.size(); i++) begin
        check_val("rd_valid_o", 1, rd_valid_o);
        check_val("rd_data_o", exp_q[i], rd_data_o);
        check_val("rd_last_o", i == exp_q.size() - 1, rd_last_o);
        @(negedge ps_clk);
      end
      check_val("rd_valid_o after last", 0, rd_valid_o);
    end
  endtask

  task automatic abort_readout();
    send_cmd(op_readout_start, 1'b0);
    wait_valid();
    send_cmd(op_readout_reset, 1'b0);
    check_val("rd_valid_o after readout reset", 0, rd_valid_o);
    check_val("rd_busy_o after readout reset", 0, rd_busy_o);
  endtask

  task automatic reset_capture();
    send_cmd(op_capture_reset, 1'b0);
    q0.delete();
    q1.delete();
    saving_m = 1'b0;
    check_val("full_o after capture reset", 0, full_o);
    check_val("depth0_o after capture reset", 0, depth0_o);
    check_val("depth1_o after capture reset", 0, depth1_o);
  endtask

  initial begin
    int fd;
    int cnt;
    int n_tests;
    int mode;
    int arm;
    int n;
    int d0;
    int d1;
    int base;
    reg [8*8-1:0]   stop_kind;
    reg [8*8-1:0]   rst_kind;
    reg [8*128-1:0] line;
    rst_i          = 1'b1;
    cmd_valid_i    = 1'b0;
    cmd_i          = '0;
    hw_start_i     = 1'b0;
    hw_stop_i      = 1'b0;
    sample_valid_i = 1'b0;
    ch0_i          = '0;
    ch1_i          = '0;
    lcg_state      = 32'h7731;
    saving_m       = 1'b0;
    n_tests        = 0;
    repeat (3) @(negedge ps_clk);
    rst_i = 1'b0;
    fd = $fopen("bench/buffer_tests.txt", "r");
    if (fd == 0) fail_now("cannot open bench/buffer_tests.txt");
    line = '0;
    while ($fgets(line, fd) > 0) begin
      cnt = $sscanf(line, "%s %d %d %d %s %s %d %d", test_name, mode, arm, n,
                    stop_kind, rst_kind, d0, d1);
      // comment and blank lines do not give eight fields
      if (cnt == 8) begin
        n_tests++;
        limit_m = (mode == 1) ? bank_depth : total_depth;
        send_cmd(op_bank_mode, mode[0]);
        // optional first capture that gets thrown away
        if (rst_kind == "armed") begin
          send_cmd(op_arm, 1'b0);
          reset_capture();
        end else if (rst_kind == "saving") begin
          capture(1'b1, 5, 1'b0);
          reset_capture();
        end else if (rst_kind == "hold") begin
          base = depth_pulses;
          capture(1'b1, 3, 1'b1);
          wait_report(1'b1, base);
          reset_capture();
        end
        base = depth_pulses;
        capture(arm[0], n, stop_kind == "stop");
        wait_report(arm[0], base);
        if (arm[0]) begin
          check_val("depth0_o", d0, depth0_o);
          check_val("depth1_o", d1, depth1_o);
        end
        check_val("full_o", q0.size() == limit_m, full_o);
        // pairs in mode 1 and channel 0 alone across both banks in mode 0
        check_val("stored samples", (mode == 1) ? d0 : d0 + d1, q0.size());
        exp_q.delete();
        for (int i = 0; i < q0.size(); i++) exp_q.push_back(q0[i]);
        if (mode == 1) begin
          check_val("stored channel 1 samples", d1, q1.size());
          for (int i = 0; i < q1.size(); i++) exp_q.push_back(q1[i]);
        end
        if (rst_kind == "readout") abort_readout();
        read_stream();
        reset_capture();
      end
      line = '0;
    end
    $fclose(fd);
    if (n_tests == 0) begin
      fail_now("no test rows found in bench/buffer_tests.txt");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* bench/buffer_tests.txt */
# name mode arm samples stop reset depth0 depth1
# stop is stop for a hw_stop_i pulse or full for none
# reset is none, armed, saving, hold or readout
stop_m1_n5      1 1  5 stop none     5  5
stop_m1_n1      1 1  1 stop none     1  1
stop_m1_n15     1 1 15 stop none    15 15
stop_m1_n0      1 1  0 stop none     0  0
stop_m0_n7      0 1  7 stop none     7  0
stop_m0_n1      0 1  1 stop none     1  0
stop_m0_n16     0 1 16 stop none    16  0
stop_m0_n20     0 1 20 stop none    16  4
stop_m0_n31     0 1 31 stop none    16 15
full_m1         1 1 16 full none    16 16
full_m1_extra   1 1 20 full none    16 16
full_m0         0 1 32 full none    16 16
full_m0_extra   0 1 36 full none    16 16
noarm_m1        1 0  6 stop none     0  0
noarm_m0        0 0  6 stop none     0  0
caprst_armed_m1 1 1  9 stop armed    9  9
caprst_armed_m0 0 1 18 stop armed   16  2
caprst_save_m1  1 1  8 stop saving   8  8
caprst_save_m0  0 1 32 full saving  16 16
caprst_hold_m1  1 1  4 stop hold     4  4
caprst_hold_m0  0 1 12 stop hold    12  0
rdrst_m1        1 1 12 stop readout 12 12
rdrst_m0        0 1 30 stop readout 16 14
rdrst_full_m1   1 1 16 full readout 16 16

/* filelist.f */
design/buffer_pkg.sv
design/cmd_decode.sv
design/capture_fsm.sv
design/sample_banks.sv
design/readout_engine.sv
design/sample_buffer_top.sv
bench/buffer_tb.sv
